// ==== bpu.f ====
+incdir+logic
logic/bpu_pkg.sv
logic/bht_store.sv
logic/branch_resolve.sv
logic/pc_select.sv
logic/bpu_ctrl.sv
logic/bpu_top.sv
test/bpu_sva.sv
test/bpu_tb.sv

// ==== test/bpu_tb.sv ====
`include "bpu_config.svh"

module bpu_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import bpu_pkg::*;

	localparam int CLK_NS = 20;
	localparam int RST_CYCLES = 16;
	localparam int WAYS = 1 << `BPU_WAY_W;

	// cycles per test
	localparam int T1_CYC = 20;
	localparam int T2_CYC = 7;
	localparam int T3_CYC = 5;
	localparam int T4_CYC = 64;
	localparam int T5_CYC = 10;
	localparam int T6_CYC = 14;
	localparam int ALL_CYC = RST_CYCLES + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + T6_CYC + 8;
	// double the run as margin
	localparam int WATCHDOG_NS = 2 * ALL_CYC * CLK_NS;

	// fixed addresses, branch in set 3 and jump in set 0
	localparam addr_t BR_PC = 11'h123;
	localparam addr_t BR_TGT = 11'h3a0;
	localparam addr_t JMP_PC = 11'h250;
	localparam addr_t JMP_TGT = 11'h111;
	localparam addr_t NEW_PC = 11'h3c7;

	// outputs expected in one cycle
	typedef struct packed {
		addr_t next_pc;
		logic  if_taken;
		corr_t correction;
		logic  flush;
		logic  id_jump_hit;
	} expect_t;

	logic      CLK;
	logic      nrst;
	logic      stall;
	addr_t     if_pc;
	id_info_t  id;
	exe_info_t exe;
	addr_t     next_pc;
	logic      if_taken;
	corr_t     correction;
	logic      flush;
	logic      id_jump_hit;

	// model of the table, fifo pointers and flush hold
	bht_entry_t            model_mem [`BPU_ENTRIES];
	logic [`BPU_WAY_W-1:0] model_ptr [1 << `BPU_SET_W];
	logic                  model_hold;
	expect_t               exp_out;

	int errors;
	int checks;
	int tests;
	int test_err;
	int sva_fails;

	bpu_top i_bpu_top (
		.CLK         (CLK),
		.nrst        (nrst),
		.stall       (stall),
		.if_pc       (if_pc),
		.id          (id),
		.exe         (exe),
		.next_pc     (next_pc),
		.if_taken    (if_taken),
		.correction  (correction),
		.flush       (flush),
		.id_jump_hit (id_jump_hit)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_NS / 2) CLK = ~CLK;
	end

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	// set from the low pc bits, tag from the rest
	function automatic bht_look_t lookup_model(input addr_t pc);
		bht_look_t  look;
		bht_entry_t ent;
		look = '0;
		for (int w = 0; w < WAYS; w++) begin
			ent = model_mem[{pc[`BPU_SET_W-1:0], w[`BPU_WAY_W-1:0]}];
			if (ent.valid && ent.tag == pc[`BPU_PC_W-1:`BPU_SET_W]) begin
				look.hit = 1'b1;
				look.way = w[`BPU_WAY_W-1:0];
				look.entry = ent;
			end
		end
		return look;
	endfunction

	// branch condition from zero and less flags
	function automatic logic branch_taken(input br_op_t op, input logic z, input logic less);
		case (op)
			BR_BEQ, BR_BEQZ: return z;
			BR_BNE, BR_BNEZ: return !z;
			BR_BLT, BR_BLTU: return less;
			BR_BGE, BR_BGEU: return !less;
			default: return 1'b0;
		endcase
	endfunction

	function automatic expect_t expected_outputs();
		expect_t   e;
		bht_look_t il;
		bht_look_t dl;
		bht_look_t el;
		logic      taken;
		logic      mis;
		il = lookup_model(if_pc);
		dl = lookup_model(id.pc);
		el = lookup_model(exe.pc);
		taken = branch_taken(exe.op, exe.z, exe.less);
		// a miss was fetched as not taken
		mis = exe.op != BR_NONE && ((el.hit && el.entry.ctr[1]) != taken);
		e.correction = !mis ? CORR_NONE : (taken ? CORR_PBT : CORR_CNI);
		e.id_jump_hit = id.is_jump && dl.hit;
		e.flush = model_hold || mis;
		e.if_taken = il.hit && il.entry.ctr[1];
		if (mis)
			e.next_pc = taken ? exe.target : addr_t'(exe.pc + 11'd1);
		else if (id.is_jump && !dl.hit)
			e.next_pc = id.target;
		else if (e.if_taken)
			e.next_pc = il.entry.target;
		else
			e.next_pc = addr_t'(if_pc + 11'd1);
		return e;
	endfunction

	// state change seen at the coming clock edge
	task automatic apply_writes(input logic mis);
		bht_look_t             dl;
		bht_look_t             el;
		bht_entry_t            ent;
		logic [`BPU_SET_W-1:0] s;
		logic                  taken;
		dl = lookup_model(id.pc);
		el = lookup_model(exe.pc);
		taken = branch_taken(exe.op, exe.z, exe.less);
		if (stall)
			return;
		if ((id.is_branch || id.is_jump) && !dl.hit) begin
			// jumps strongly taken, branches weakly not taken
			s = id.pc[`BPU_SET_W-1:0];
			ent = '{1'b1, id.pc[`BPU_PC_W-1:`BPU_SET_W], id.target, id.is_jump ? 2'd3 : 2'd1};
			model_mem[{s, model_ptr[s]}] = ent;
			model_ptr[s] = model_ptr[s] + 1'b1;
		end else if (exe.op != BR_NONE && el.hit) begin
			s = exe.pc[`BPU_SET_W-1:0];
			if (taken && el.entry.ctr != 2'd3)
				model_mem[{s, el.way}].ctr = el.entry.ctr + 2'd1;
			else if (!taken && el.entry.ctr != 2'd0)
				model_mem[{s, el.way}].ctr = el.entry.ctr - 2'd1;
		end
		model_hold = !model_hold && (mis || (id.is_jump && !dl.hit));
	endtask

	task automatic clear_model();
		for (int i = 0; i < `BPU_ENTRIES; i++)
			model_mem[i] = '0;
		for (int s = 0; s < (1 << `BPU_SET_W); s++)
			model_ptr[s] = '0;
		model_hold = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_corr(input string name, input corr_t got, input corr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s got %s expected %s", $time, name, got.name(), exp.name());
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// outputs are settled mid-cycle, model steps after the checks
	always @(negedge CLK) begin
		if (!nrst) begin
			clear_model();
		end else begin
			exp_out = expected_outputs();
			check_addr("next_pc", next_pc, exp_out.next_pc);
			check_bit("if_taken", if_taken, exp_out.if_taken);
			check_corr("correction", correction, exp_out.correction);
			check_bit("flush", flush, exp_out.flush);
			check_bit("id_jump_hit", id_jump_hit, exp_out.id_jump_hit);
			apply_writes(exp_out.correction != CORR_NONE);
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	task automatic drive(input addr_t pc, input id_info_t d, input exe_info_t x, input logic st);
		@(posedge CLK);
		if_pc <= pc;
		id <= d;
		exe <= x;
		stall <= st;
	endtask

	function automatic id_info_t id_item(input logic br, input logic jmp, input addr_t pc,
		input addr_t tgt);
		return '{br, jmp, pc, tgt};
	endfunction

	function automatic exe_info_t exe_item(input br_op_t op, input addr_t pc, input addr_t tgt,
		input logic z, input logic less);
		return '{op, pc, tgt, z, less};
	endfunction

	task automatic start_test();
		test_err = errors;
	endtask

	// last cycle of the test is checked at the next falling edge
	task automatic end_test(input string name);
		@(negedge CLK);
		#1;
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - test_err);
	endtask

	initial begin
		void'($urandom(92));
		nrst = 1'b0;
		stall = 1'b0;
		if_pc = '0;
		id = '0;
		exe = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		repeat (RST_CYCLES) @(posedge CLK);
		nrst <= 1'b1;

		// empty table, everything falls through to pc+1
		start_test();
		for (int i = 0; i < T1_CYC; i++)
			drive(addr_t'($urandom), '0, '0, 1'b0);
		end_test("reset state");

		// allocate weakly not taken, train up to saturation
		start_test();
		drive(11'h000, id_item(1'b1, 1'b0, BR_PC, BR_TGT), '0, 1'b0);
		for (int i = 0; i < 5; i++)
			drive(BR_PC, '0, exe_item(BR_BEQ, BR_PC, BR_TGT, 1'b1, 1'b0), 1'b0);
		drive(BR_PC, '0, '0, 1'b0);
		end_test("branch training");

		// jump miss flushes once, the hit afterwards does not
		start_test();
		drive(11'h040, id_item(1'b0, 1'b1, JMP_PC, JMP_TGT), '0, 1'b0);
		drive(JMP_TGT, '0, '0, 1'b0);
		drive(11'h041, id_item(1'b0, 1'b1, JMP_PC, JMP_TGT), '0, 1'b0);
		drive(JMP_PC, '0, '0, 1'b0);
		drive(11'h042, '0, '0, 1'b0);
		end_test("jump allocation");

		// every opcode, random flags, hit on odd rounds for cni
		start_test();
		for (int k = 1; k <= 8; k++) begin
			for (int i = 0; i < 4; i++) begin
				drive(addr_t'($urandom), '0,
					exe_item(br_op_t'(k), i[0] ? BR_PC : addr_t'($urandom),
					addr_t'($urandom), 1'($urandom), 1'($urandom)), 1'b0);
				drive(addr_t'($urandom), '0, '0, 1'b0);
			end
		end
		end_test("mispredict correction");

		// five tags in set 5, first one must be gone
		start_test();
		for (int k = 0; k < 5; k++)
			drive(11'h000, id_item(1'b0, 1'b1, {7'(k + 8), 4'h5}, addr_t'($urandom)), '0, 1'b0);
		for (int k = 0; k < 5; k++)
			drive({7'(k + 8), 4'h5}, '0, '0, 1'b0);
		end_test("fifo eviction");

		// stall holds flush and blocks the writes
		start_test();
		// saturate, then two not-taken steps leave the counter at 1
		for (int i = 0; i < 3; i++)
			drive(11'h064, '0, exe_item(BR_BEQ, BR_PC, BR_TGT, 1'b1, 1'b0), 1'b0);
		for (int i = 0; i < 2; i++)
			drive(11'h065, '0, exe_item(BR_BEQ, BR_PC, BR_TGT, 1'b0, 1'b0), 1'b0);
		drive(11'h060, '0, exe_item(BR_BNE, 11'h061, 11'h070, 1'b0, 1'b0), 1'b0);
		// flush in the second stalled cycle comes only from the frozen hold
		drive(11'h061, '0, '0, 1'b1);
		drive(11'h062, '0, '0, 1'b1);
		// a leaked write would show as a taken prediction later
		drive(11'h062, id_item(1'b0, 1'b1, NEW_PC, 11'h010),
			exe_item(BR_BEQ, BR_PC, BR_TGT, 1'b1, 1'b0), 1'b1);
		drive(11'h063, '0, '0, 1'b0);
		drive(NEW_PC, '0, '0, 1'b0);
		// jump allocation and a taken step in the same cycle
		drive(11'h066, id_item(1'b0, 1'b1, NEW_PC, 11'h010),
			exe_item(BR_BEQ, BR_PC, BR_TGT, 1'b1, 1'b0), 1'b0);
		drive(BR_PC, '0, '0, 1'b0);
		drive(NEW_PC, '0, '0, 1'b0);
		end_test("stall and write priority");

		sva_fails = i_bpu_top.i_bpu_sva.fail_count;
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
			tests, checks, errors, sva_fails);
		if (errors == 0 && sva_fails == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run still going after %0d ns", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== test/bpu_sva.sv ====
module bpu_sva (
	input logic               CLK,
	input logic               nrst,
	input logic               stall,
	input bpu_pkg::exe_info_t exe,
	input bpu_pkg::corr_t     correction,
	input logic               flush
);
	timeunit 1ns;
	timeprecision 1ps;
	import bpu_pkg::*;

	// failed assertions so far, the testbench reads this at the end
	int fail_count = 0;

	// three flush cycles in a row need a fresh mispredict
	// stall freezes the hold register, so stalled cycles are left out
	property p_flush_len;
		@(posedge CLK) disable iff (!nrst)
		(flush && !stall) ##1 (flush && !stall) ##1 flush
			|-> (correction != CORR_NONE || $past(correction) != CORR_NONE);
	endproperty

	// no branch in exe, nothing to correct
	property p_corr_idle;
		@(posedge CLK) disable iff (!nrst)
		exe.op == BR_NONE |-> correction == CORR_NONE;
	endproperty

	// fsm leaves reset idle
	property p_reset_flush;
		@(posedge CLK) $rose(nrst) |-> !flush;
	endproperty

	a_flush_len: assert property (p_flush_len) else begin
		fail_count++;
		$error("flush stayed high three cycles without a new mispredict");
	end

	a_corr_idle: assert property (p_corr_idle) else begin
		fail_count++;
		$error("correction raised while exe holds no branch");
	end

	a_reset_flush: assert property (p_reset_flush) else begin
		fail_count++;
		$error("flush high in the first cycle after reset");
	end

endmodule

bind bpu_top bpu_sva i_bpu_sva (.*);

// ==== logic/bpu_top.sv ====
module bpu_top (
	input  logic               CLK,
	input  logic               nrst,
	input  logic               stall,
	input  bpu_pkg::addr_t     if_pc,
	input  bpu_pkg::id_info_t  id,
	input  bpu_pkg::exe_info_t exe,
	output bpu_pkg::addr_t     next_pc,
	output logic               if_taken,
	output bpu_pkg::corr_t     correction,
	output logic               flush,
	output logic               id_jump_hit
);
	import bpu_pkg::*;

	// lookups of the three stages
	bht_look_t  if_look;
	bht_look_t  id_look;
	bht_look_t  exe_look;

	bht_write_t wr;
	resolve_t   res;

	// table, one write port and three read ports
	bht_store i_bht_store (
		.CLK      (CLK),
		.nrst     (nrst),
		.if_pc    (if_pc),
		.id_pc    (id.pc),
		.exe_pc   (exe.pc),
		.wr       (wr),
		.if_look  (if_look),
		.id_look  (id_look),
		.exe_look (exe_look)
	);

	// exe outcome against the stored prediction
	branch_resolve i_branch_resolve (
		.exe      (exe),
		.exe_look (exe_look),
		.res      (res)
	);

	bpu_ctrl i_bpu_ctrl (
		.CLK         (CLK),
		.nrst        (nrst),
		.stall       (stall),
		.id          (id),
		.id_look     (id_look),
		.exe         (exe),
		.res         (res),
		.wr          (wr),
		.correction  (correction),
		.flush       (flush),
		.id_jump_hit (id_jump_hit)
	);

	// next fetch address
	pc_select i_pc_select (
		.if_pc       (if_pc),
		.if_look     (if_look),
		.id          (id),
		.id_jump_hit (id_jump_hit),
		.exe         (exe),
		.correction  (correction),
		.next_pc     (next_pc),
		.if_taken    (if_taken)
	);

endmodule

// ==== logic/bpu_ctrl.sv ====
module bpu_ctrl (
	input  logic                CLK,
	input  logic                nrst,
	input  logic                stall,
	input  bpu_pkg::id_info_t   id,
	input  bpu_pkg::bht_look_t  id_look,
	input  bpu_pkg::exe_info_t  exe,
	input  bpu_pkg::resolve_t   res,
	output bpu_pkg::bht_write_t wr,
	output bpu_pkg::corr_t      correction,
	output logic                flush,
	output logic                id_jump_hit
);
	import bpu_pkg::*;

	// initial counters, strongly taken and weakly not taken
	localparam ctr_t CTR_ST = 2'b11;
	localparam ctr_t CTR_WNT = 2'b01;

	logic      alloc_req;
	logic      train_req;
	logic      id_jump_miss;
	flush_st_t fl_state;
	flush_st_t fl_next;

	////////////////////////////////////////////////////////////
	// table write arbitration
	////////////////////////////////////////////////////////////

	// decode allocates anything control-flow that misses
	assign alloc_req = (id.is_branch || id.is_jump) && !id_look.hit;
	assign train_req = res.active;

	always_comb begin
		wr.op = WR_NONE;
		wr.pc = exe.pc;
		wr.target = exe.target;
		wr.ctr = id.is_jump ? CTR_ST : CTR_WNT;
		wr.taken = res.taken;
		// table frozen while stalled
		if (!stall) begin
			if (alloc_req) begin
				// allocation wins, same-cycle training is dropped
				wr.op = WR_ALLOC;
				wr.pc = id.pc;
				wr.target = id.target;
			end else if (train_req) begin
				wr.op = WR_TRAIN;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// correction and decode jump status
	////////////////////////////////////////////////////////////

	// not taken after all goes to pc+1, taken goes to the target
	always_comb begin
		if (!res.mispredict) begin
			correction = CORR_NONE;
		end else if (res.taken) begin
			correction = CORR_PBT;
		end else begin
			correction = CORR_CNI;
		end
	end

	assign id_jump_hit = id.is_jump && id_look.hit;
	assign id_jump_miss = id.is_jump && !id_look.hit;

	////////////////////////////////////////////////////////////
	// flush fsm
	////////////////////////////////////////////////////////////

	// hold stretches the flush one more cycle
	always_comb begin
		fl_next = fl_state;
		case (fl_state)
			FL_IDLE: begin
				if (res.mispredict || id_jump_miss) begin
					fl_next = FL_HOLD;
				end
			end
			FL_HOLD: fl_next = FL_IDLE;
			default: fl_next = FL_IDLE;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			fl_state <= FL_IDLE;
		end else if (!stall) begin
			fl_state <= fl_next;
		end
	end

	// a mispredict flushes at once, a decode jump miss only via hold
	assign flush = (fl_state == FL_HOLD) || res.mispredict;

endmodule

// ==== logic/pc_select.sv ====
module pc_select (
	input  bpu_pkg::addr_t     if_pc,
	input  bpu_pkg::bht_look_t if_look,
	input  bpu_pkg::id_info_t  id,
	input  logic               id_jump_hit,
	input  bpu_pkg::exe_info_t exe,
	input  bpu_pkg::corr_t     correction,
	output bpu_pkg::addr_t     next_pc,
	output logic               if_taken
);
	import bpu_pkg::*;

	addr_t if_seq;
	addr_t exe_seq;
	logic  id_jump_miss;

	// sequential addresses, word granular so plus one
	assign if_seq = if_pc + addr_t'(1);
	assign exe_seq = exe.pc + addr_t'(1);

	// predict taken only on a hit with counter msb set
	assign if_taken = if_look.hit && if_look.entry.ctr[1];

	// jump not yet in the table, target only known at decode
	assign id_jump_miss = id.is_jump && !id_jump_hit;

	// oldest stage wins, exe correction first
	always_comb begin
		if (correction == CORR_CNI) begin
			next_pc = exe_seq;
		end else if (correction == CORR_PBT) begin
			next_pc = exe.target;
		end else if (id_jump_miss) begin
			next_pc = id.target;
		end else if (if_taken) begin
			next_pc = if_look.entry.target;
		end else begin
			next_pc = if_seq;
		end
	end

endmodule

// ==== logic/branch_resolve.sv ====
module branch_resolve (
	input  bpu_pkg::exe_info_t exe,
	input  bpu_pkg::bht_look_t exe_look,
	output bpu_pkg::resolve_t  res
);
	import bpu_pkg::*;

	// real outcome from the alu flags
	logic cond_taken;

	// what fetch assumed back then
	logic pred_taken;

	////////////////////////////////////////////////////////////
	// condition decode
	////////////////////////////////////////////////////////////

	always_comb begin
		case (exe.op)
			// equality tests use the zero flag
			BR_BEQ: cond_taken = exe.z;
			BR_BEQZ: cond_taken = exe.z;
			BR_BNE: cond_taken = !exe.z;
			BR_BNEZ: cond_taken = !exe.z;
			// signed and unsigned compares both come in as less
			BR_BLT: cond_taken = exe.less;
			BR_BLTU: cond_taken = exe.less;
			BR_BGE: cond_taken = !exe.less;
			BR_BGEU: cond_taken = !exe.less;
			default: cond_taken = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// prediction check
	////////////////////////////////////////////////////////////

	// a table miss was fetched as not taken
	assign pred_taken = exe_look.hit && exe_look.entry.ctr[1];

	always_comb begin
		res.active = (exe.op != BR_NONE);
		res.taken = cond_taken;
		// only a real branch can mispredict
		res.mispredict = res.active && (pred_taken != cond_taken);
	end

endmodule

// ==== logic/bht_store.sv ====
`include "bpu_config.svh"

module bht_store (
	input  logic                CLK,
	input  logic                nrst,
	input  bpu_pkg::addr_t      if_pc,
	input  bpu_pkg::addr_t      id_pc,
	input  bpu_pkg::addr_t      exe_pc,
	input  bpu_pkg::bht_write_t wr,
	output bpu_pkg::bht_look_t  if_look,
	output bpu_pkg::bht_look_t  id_look,
	output bpu_pkg::bht_look_t  exe_look
);
	import bpu_pkg::*;

	localparam int SETS = 1 << `BPU_SET_W;
	localparam int WAYS = 1 << `BPU_WAY_W;

	// entry index is {set, way}
	bht_entry_t bht_mem [`BPU_ENTRIES];

	// per-set fifo pointer, points at the oldest way
	logic [`BPU_WAY_W-1:0] fifo_ptr [SETS];

	logic [`BPU_SET_W-1:0] wr_set;
	logic [`BPU_SET_W-1:0] exe_set;
	bht_entry_t            alloc_entry;
	bht_entry_t            train_entry;

	////////////////////////////////////////////////////////////
	// address split
	////////////////////////////////////////////////////////////

	// low bits pick the set
	function automatic logic [`BPU_SET_W-1:0] set_of(input addr_t pc);
		return pc[`BPU_SET_W-1:0];
	endfunction

	// upper bits form the tag
	function automatic logic [`BPU_TAG_W-1:0] tag_of(input addr_t pc);
		return pc[`BPU_PC_W-1:`BPU_SET_W];
	endfunction

	// saturating step of the 2-bit counter
	function automatic ctr_t ctr_step(input ctr_t ctr, input logic taken);
		ctr_t nxt;
		nxt = ctr;
		if (taken && ctr != 2'b11) begin
			nxt = ctr + 2'b01;
		end else if (!taken && ctr != 2'b00) begin
			nxt = ctr - 2'b01;
		end
		return nxt;
	endfunction

	////////////////////////////////////////////////////////////
	// lookup ports
	////////////////////////////////////////////////////////////

	// compare the tag against all ways of the set
	// a miss returns an all-zero entry, so the counter reads not taken
	function automatic bht_look_t lookup(input addr_t pc);
		bht_look_t                look;
		bht_entry_t               ent;
		logic [`BPU_SET_W-1:0]    set;
		logic [`BPU_WAY_W-1:0]    way;
		set = set_of(pc);
		look = '0;
		for (int w = 0; w < WAYS; w++) begin
			way = w[`BPU_WAY_W-1:0];
			ent = bht_mem[{set, way}];
			if (ent.valid && ent.tag == tag_of(pc)) begin
				look.hit = 1'b1;
				look.way = way;
				look.entry = ent;
			end
		end
		return look;
	endfunction

	// one lookup per pipeline stage
	always_comb begin
		if_look = lookup(if_pc);
	end

	always_comb begin
		id_look = lookup(id_pc);
	end

	always_comb begin
		exe_look = lookup(exe_pc);
	end

	////////////////////////////////////////////////////////////
	// write port
	////////////////////////////////////////////////////////////

	assign wr_set = set_of(wr.pc);
	assign exe_set = set_of(exe_pc);

	// fresh entry, counter comes from the allocating stage
	always_comb begin
		alloc_entry.valid = 1'b1;
		alloc_entry.tag = tag_of(wr.pc);
		alloc_entry.target = wr.target;
		alloc_entry.ctr = wr.ctr;
	end

	// training only moves the counter of the hit line
	always_comb begin
		train_entry = exe_look.entry;
		train_entry.ctr = ctr_step(exe_look.entry.ctr, wr.taken);
	end

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			for (int i = 0; i < `BPU_ENTRIES; i++) begin
				bht_mem[i] <= '0;
			end
			for (int s = 0; s < SETS; s++) begin
				fifo_ptr[s] <= '0;
			end
		end else begin
			case (wr.op)
				WR_ALLOC: begin
					// replace the oldest way, then move on
					bht_mem[{wr_set, fifo_ptr[wr_set]}] <= alloc_entry;
					fifo_ptr[wr_set] <= fifo_ptr[wr_set] + 1'b1;
				end
				WR_TRAIN: begin
					// evicted or never allocated, nothing to train
					if (exe_look.hit) begin
						bht_mem[{exe_set, exe_look.way}] <= train_entry;
					end
				end
				default: begin
				end
			endcase
		end
	end

endmodule

// ==== logic/bpu_pkg.sv ====
`include "bpu_config.svh"

package bpu_pkg;

	// word address as seen by the fetch unit
	typedef logic [`BPU_PC_W-1:0] addr_t;

	// 2-bit saturating counter, msb gives the prediction
	typedef logic [1:0] ctr_t;

	// branch opcode decoded for exe
	typedef enum logic [3:0] {
		BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
		BR_BLTU, BR_BGEU, BR_BEQZ, BR_BNEZ
	} br_op_t;

	// one table line, valid in the msb
	typedef struct packed {
		logic                  valid;
		logic [`BPU_TAG_W-1:0] tag;
		addr_t                 target;
		ctr_t                  ctr;
	} bht_entry_t;

	// result of one set-associative lookup
	typedef struct packed {
		logic                  hit;
		logic [`BPU_WAY_W-1:0] way;
		bht_entry_t            entry;
	} bht_look_t;

	// instruction sitting in decode
	typedef struct packed {
		logic  is_branch;
		logic  is_jump;
		addr_t pc;
		addr_t target;
	} id_info_t;

	// instruction sitting in execute, with alu flags
	typedef struct packed {
		br_op_t op;
		addr_t  pc;
		addr_t  target;
		logic   z;
		logic   less;
	} exe_info_t;

	typedef enum logic [1:0] {WR_NONE, WR_ALLOC, WR_TRAIN} wr_op_t;

	// write command into the table
	typedef struct packed {
		wr_op_t op;
		addr_t  pc;
		addr_t  target;
		ctr_t   ctr;
		logic   taken;
	} bht_write_t;

	// cni = correct next instruction, pbt = predicted branch target
	typedef enum logic [1:0] {CORR_NONE, CORR_CNI, CORR_PBT} corr_t;

	typedef enum logic {FL_IDLE, FL_HOLD} flush_st_t;

	typedef struct packed {
		logic active;
		logic taken;
		logic mispredict;
	} resolve_t;

endpackage

// ==== logic/bpu_config.svh ====
`ifndef BPU_CONFIG_SVH
`define BPU_CONFIG_SVH

////////////////////////////////////////////////////////////
// branch predictor geometry
////////////////////////////////////////////////////////////

// pc is a word address, not a byte address
`define BPU_PC_W 11

// 16 sets, indexed by the low pc bits
`define BPU_SET_W 4

// 4 ways per set
`define BPU_WAY_W 2

// tag is whatever is left above the set index
`define BPU_TAG_W 7

// sets times ways
`define BPU_ENTRIES 64

`endif
